// ==== hdl/gomoku_pkg.sv ====
// gomoku package: cell and board types plus the game constants shared by the solver
`default_nettype none

package gomoku_pkg;

    // largest supported board edge, sizes all board storage
    localparam int MAX_BOARD_N = 15;

    // stones needed in one line for a win
    localparam int WIN_LEN = 5;

    // width of the remaining-ply count
    localparam int PLY_W = 4;

    // one row word, two bits per column, column 0 in the low bits
    localparam int ROW_W = MAX_BOARD_N * 2;

    // state of a single cell
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_EMPTY = 2'd0;
    localparam cell_t CELL_BLACK = 2'd1;
    localparam cell_t CELL_WHITE = 2'd2;

    // board[row][col], 450 bits
    // with a smaller board only the top-left square is used
    typedef cell_t [MAX_BOARD_N-1:0][MAX_BOARD_N-1:0] board_t;

endpackage

`default_nettype wire

// ==== hdl/search_if.sv ====
// search_if: request and verdict between one search ply and the ply below it
`timescale 1ns/1ps
`default_nettype none

interface search_if import gomoku_pkg::*; ();

    // one-cycle request pulse from the parent
    logic             start;
    // trial board, held while the child works
    board_t           board;
    // plies still allowed below the child
    logic [PLY_W-1:0] remain;
    // one-cycle answer pulse from the child
    logic             done;
    // black wins from that board, valid with done
    logic             win;

    modport parent (
        output start,
        output board,
        output remain,
        input  done,
        input  win
    );

    modport child (
        input  start,
        input  board,
        input  remain,
        output done,
        output win
    );

endinterface

`default_nettype wire

// ==== hdl/board_loader.sv ====
// board_loader: stores board rows, latches the search depth and launches the root ply
`timescale 1ns/1ps
`default_nettype none

module board_loader import gomoku_pkg::*; #(
    parameter int BOARD_N   = 15,
    parameter int MAX_DEPTH = 2
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_row_we,
    input  logic [3:0]       i_row_idx,
    input  logic [ROW_W-1:0] i_row_data,
    input  logic             i_start,
    input  logic [1:0]       i_depth,
    input  logic             i_busy,
    search_if.parent         o_root
);

    // deepest depth the chain can serve
    localparam logic [1:0] DEPTH_CAP = (MAX_DEPTH >= 3) ? 2'd3 : 2'(MAX_DEPTH);

    board_t     board_q;
    logic [1:0] depth_q;
    logic       start_q;
    logic       launch;
    logic       row_ok;

    assign launch = i_start && !i_busy;
    assign row_ok = (int'(i_row_idx) < BOARD_N);

    // board and depth are payload only
    always_ff @(posedge i_clk) begin
        if (i_row_we && !i_busy && row_ok) begin
            board_q[i_row_idx] <= i_row_data;
        end
        if (launch) begin
            if (i_depth > DEPTH_CAP) begin
                depth_q <= DEPTH_CAP;
            end else begin
                depth_q <= i_depth;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= launch;
        end
    end

    // black and white alternate, so two plies per depth step
    assign o_root.start  = start_q;
    assign o_root.board  = board_q;
    assign o_root.remain = PLY_W'({depth_q, 1'b0});

endmodule

`default_nettype wire

// ==== hdl/five_detect.sv ====
// five_detect: checks whether a stone at the given cell completes five of its colour
`timescale 1ns/1ps
`default_nettype none

module five_detect import gomoku_pkg::*; #(
    parameter int BOARD_N = 15
) (
    input  board_t     i_board,
    input  logic [3:0] i_row,
    input  logic [3:0] i_col,
    input  cell_t      i_color,
    output logic       o_five
);

    // row, column, main diagonal, anti diagonal
    localparam int DR [4] = '{0, 1, 1, 1};
    localparam int DC [4] = '{1, 0, 1, -1};

    // consecutive same-colour stones from the cell outward, cell excluded
    function automatic int run_len(input int dr, input int dc);
        int   r;
        int   c;
        int   n;
        logic open;
        n    = 0;
        open = 1'b1;
        for (int s = 1; s < WIN_LEN; s++) begin
            r = int'(i_row) + s * dr;
            c = int'(i_col) + s * dc;
            if (r < 0 || r >= BOARD_N || c < 0 || c >= BOARD_N) begin
                open = 1'b0;
            end else if (i_board[r[3:0]][c[3:0]] != i_color) begin
                open = 1'b0;
            end
            if (open) begin
                n++;
            end
        end
        return n;
    endfunction

    always_comb begin
        int total;
        o_five = 1'b0;
        for (int d = 0; d < 4; d++) begin
            // the placed stone itself plus both arms
            total = 1 + run_len(DR[d], DC[d]) + run_len(-DR[d], -DC[d]);
            // longer lines count as five too
            if (total >= WIN_LEN) begin
                o_five = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/kill_node.sv ====
// kill_node: one search ply that tries each empty cell, asks the next ply and merges verdicts
`timescale 1ns/1ps
`default_nettype none

module kill_node import gomoku_pkg::*; #(
    parameter int BOARD_N = 15,
    parameter int LEVEL   = 0,
    parameter bit LAST    = 1'b0
) (
    input  logic     i_clk,
    input  logic     i_rst,
    search_if.child  up,
    search_if.parent down
);

    // black on even plies, white on odd
    localparam cell_t MOVER  = (LEVEL % 2 == 0) ? CELL_BLACK : CELL_WHITE;
    // verdict that ends the scan early: a win for black, a loss for white
    localparam logic  DECIDE = (LEVEL % 2 == 0);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_WAIT,
        ST_REPORT
    } state_t;

    state_t           state;
    board_t           board_q;
    logic [PLY_W-1:0] remain_q;
    logic [3:0]       row_q;
    logic [3:0]       col_q;
    logic             win_q;
    logic             five;
    logic             cell_free;
    logic             last_cell;
    logic             hit;
    logic             go_child;
    logic             child_done;
    logic             child_win;
    logic             child_hit;
    logic             step;
    logic             finish;

    five_detect #(
        .BOARD_N (BOARD_N)
    ) u_five (
        .i_board (board_q),
        .i_row   (row_q),
        .i_col   (col_q),
        .i_color (MOVER),
        .o_five  (five)
    );

    assign cell_free = (board_q[row_q][col_q] == CELL_EMPTY);
    assign last_cell = (row_q == 4'(BOARD_N - 1)) && (col_q == 4'(BOARD_N - 1));

    // own five decides on the spot
    assign hit       = (state == ST_SCAN) && cell_free && five;
    assign go_child  = (state == ST_SCAN) && cell_free && !five && (remain_q != '0) && !LAST;
    assign child_hit = (state == ST_WAIT) && child_done && (child_win == DECIDE);

    // move on to the next cell
    assign step   = ((state == ST_SCAN) && !hit && !go_child)
                 || ((state == ST_WAIT) && child_done && !child_hit);
    assign finish = step && last_cell;

    assign up.done = (state == ST_REPORT);
    assign up.win  = win_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (up.start) begin
                        state <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    if (hit || finish) begin
                        state <= ST_REPORT;
                    end else if (go_child) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (child_hit || finish) begin
                        state <= ST_REPORT;
                    end else if (step) begin
                        state <= ST_SCAN;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // row-major cell walk over the active square
    always_ff @(posedge i_clk) begin
        if ((state == ST_IDLE) && up.start) begin
            board_q  <= up.board;
            remain_q <= up.remain;
            row_q    <= '0;
            col_q    <= '0;
        end else if (step && !last_cell) begin
            if (col_q == 4'(BOARD_N - 1)) begin
                col_q <= '0;
                row_q <= row_q + 4'd1;
            end else begin
                col_q <= col_q + 4'd1;
            end
        end
        if (hit || child_hit) begin
            win_q <= DECIDE;
        end else if (finish) begin
            win_q <= !DECIDE;
        end
    end

    generate
        if (LAST) begin : g_leaf
            // deepest ply, nothing below
            assign down.start  = 1'b0;
            assign down.board  = '0;
            assign down.remain = '0;
            assign child_done  = 1'b0;
            assign child_win   = 1'b0;
        end else begin : g_link
            logic   start_q;
            board_t trial;

            always_ff @(posedge i_clk) begin
                if (i_rst) begin
                    start_q <= 1'b0;
                end else begin
                    start_q <= go_child;
                end
            end

            // cell counter is frozen while waiting, so the trial board holds
            always_comb begin
                trial = board_q;
                trial[row_q][col_q] = MOVER;
            end

            assign down.start  = start_q;
            assign down.board  = trial;
            assign down.remain = remain_q - PLY_W'(1);
            assign child_done  = down.done;
            assign child_win   = down.win;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/search_result.sv ====
// search_result: busy tracking plus the registered done pulse and held verdict
`timescale 1ns/1ps
`default_nettype none

module search_result (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_launch,
    input  logic i_done,
    input  logic i_win,
    output logic o_busy,
    output logic o_done,
    output logic o_win
);

    logic busy_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy_q <= 1'b0;
            o_done <= 1'b0;
            o_win  <= 1'b0;
        end else begin
            // busy drops in the same cycle as o_done
            if (i_launch) begin
                busy_q <= 1'b1;
            end else if (i_done) begin
                busy_q <= 1'b0;
            end
            o_done <= i_done;
            if (i_done) begin
                o_win <= i_win;
            end
        end
    end

    // launch cycle already counts as busy
    assign o_busy = busy_q || i_launch;

endmodule

`default_nettype wire

// ==== hdl/threat_search_top.sv ====
// threat_search_top: gomoku forced-win solver with loader, ply chain and result block
`timescale 1ns/1ps
`default_nettype none

module threat_search_top import gomoku_pkg::*; #(
    parameter int BOARD_N   = 15,
    parameter int MAX_DEPTH = 2
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_row_we,
    input  logic [3:0]       i_row_idx,
    input  logic [ROW_W-1:0] i_row_data,
    input  logic             i_start,
    input  logic [1:0]       i_depth,
    output logic             o_busy,
    output logic             o_done,
    output logic             o_win
);

    // one black ply per depth step plus the white replies between them
    localparam int NODES = 2 * MAX_DEPTH + 1;

    // link[k] runs from ply k-1 (or the loader) into ply k
    search_if link [0:NODES] ();

    board_loader #(
        .BOARD_N   (BOARD_N),
        .MAX_DEPTH (MAX_DEPTH)
    ) u_loader (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_row_we   (i_row_we),
        .i_row_idx  (i_row_idx),
        .i_row_data (i_row_data),
        .i_start    (i_start),
        .i_depth    (i_depth),
        .i_busy     (o_busy),
        .o_root     (link[0])
    );

    for (genvar k = 0; k < NODES; k++) begin : g_node
        kill_node #(
            .BOARD_N (BOARD_N),
            .LEVEL   (k),
            .LAST    (k == NODES - 1)
        ) u_node (
            .i_clk (i_clk),
            .i_rst (i_rst),
            .up    (link[k]),
            .down  (link[k+1])
        );
    end

    // no ply below the last one
    assign link[NODES].done = 1'b0;
    assign link[NODES].win  = 1'b0;

    search_result u_result (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_launch (link[0].start),
        .i_done   (link[0].done),
        .i_win    (link[0].win),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .o_win    (o_win)
    );

endmodule

`default_nettype wire

// ==== test/threat_search_assert.sv ====
// threat_search_assert: concurrent checks on the solver's control outputs
`timescale 1ns/1ps
`default_nettype none

module threat_search_assert (
    input logic i_clk,
    input logic i_rst,
    input logic i_busy,
    input logic i_done,
    input logic i_win
);

    // done is a single-cycle pulse
    assert property (@(posedge i_clk) disable iff (i_rst) i_done |=> !i_done)
        else $error("o_done held for more than one cycle");

    assert property (@(posedge i_clk) disable iff (i_rst) i_done |-> $past(i_busy))
        else $error("o_done without a search in progress");

    // verdict only moves with done
    assert property (@(posedge i_clk) disable iff (i_rst) !i_done |-> $stable(i_win))
        else $error("o_win changed outside a done pulse");

    assert property (@(posedge i_clk) (i_rst && $past(i_rst)) |-> !(i_busy || i_done || i_win))
        else $error("control outputs not cleared during reset");

endmodule

`default_nettype wire

// ==== test/threat_search_tb.sv ====
// threat_search_tb: vector-driven testbench for the gomoku threat-space solver
`timescale 1ns/1ps
`default_nettype none

module threat_search_tb import gomoku_pkg::*; ();

    localparam int BOARD_N   = 7;
    localparam int NUM_TESTS = 6;
    localparam int REC_LEN   = BOARD_N + 1;
    localparam int CELLS     = BOARD_N * BOARD_N;
    // every ply may walk the whole board, and a replay doubles a test
    localparam int CYCLE_LIMIT = NUM_TESTS * 2 * CELLS * CELLS * CELLS;

    logic             i_clk;
    logic             i_rst;
    logic             i_row_we;
    logic [3:0]       i_row_idx;
    logic [ROW_W-1:0] i_row_data;
    logic             i_start;
    logic [1:0]       i_depth;
    logic             o_busy;
    logic             o_done;
    logic             o_win;

    logic [31:0] vec_mem [NUM_TESTS*REC_LEN];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycle_cnt = 0;

    threat_search_top #(
        .BOARD_N   (BOARD_N),
        .MAX_DEPTH (1)
    ) uut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_row_we   (i_row_we),
        .i_row_idx  (i_row_idx),
        .i_row_data (i_row_data),
        .i_start    (i_start),
        .i_depth    (i_depth),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_win      (o_win)
    );

    bind threat_search_top threat_search_assert u_assert (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_busy (o_busy),
        .i_done (o_done),
        .i_win  (o_win)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the search did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic write_row(input int idx, input logic [ROW_W-1:0] data);
        i_row_we   = 1'b1;
        i_row_idx  = 4'(idx);
        i_row_data = data;
        next_cycle();
        i_row_we   = 1'b0;
    endtask

    task automatic run_search(input logic [1:0] depth, input logic exp_win, input logic meddle);
        int done_cnt;
        i_depth = depth;
        i_start = 1'b1;
        next_cycle();
        i_start = 1'b0;
        while (!o_done) begin
            compare_value("o_busy", 1, o_busy);
            if (meddle) begin
                // junk that the solver must ignore while busy
                rng_state  = xorshift32(rng_state);
                i_row_we   = 1'b1;
                i_row_idx  = rng_state[3:0];
                i_row_data = rng_state[ROW_W-1:0];
                i_start    = rng_state[31];
            end
            next_cycle();
            i_row_we = 1'b0;
            i_start  = 1'b0;
        end
        compare_value("o_busy", 0, o_busy);
        compare_value("o_win", 32'(exp_win), o_win);
        done_cnt = 1;
        repeat (4) begin
            next_cycle();
            if (o_done) begin
                done_cnt++;
            end
            compare_value("o_win", 32'(exp_win), o_win);
        end
        compare_value("o_done pulses", 1, done_cnt);
    endtask

    initial begin
        logic [31:0] cmd;
        int          base;
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        i_row_we   = 1'b0;
        i_row_idx  = '0;
        i_row_data = '0;
        i_start    = 1'b0;
        i_depth    = '0;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'h188d_b667;
        $readmemh("test/threat_search_vectors.txt", vec_mem);
        repeat (4) next_cycle();
        compare_value("o_busy", 0, o_busy);
        compare_value("o_done", 0, o_done);
        compare_value("o_win", 0, o_win);
        i_rst = 1'b0;
        next_cycle();
        for (int t = 0; t < NUM_TESTS; t++) begin
            base = t * REC_LEN;
            cmd  = vec_mem[base+BOARD_N];
            for (int r = 0; r < BOARD_N; r++) begin
                write_row(r, vec_mem[base+r][ROW_W-1:0]);
            end
            if (cmd[8]) begin
                // rows past the board edge, all black
                for (int r = BOARD_N; r < 16; r++) begin
                    write_row(r, 30'h1555_5555);
                end
            end
            run_search(cmd[5:4], cmd[0], cmd[8]);
            // board must have survived the junk writes
            if (cmd[8]) begin
                run_search(cmd[5:4], cmd[0], 1'b0);
            end
        end
        $display("errors: %0d of %0d checks failed", errors, checks);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/gomoku_pkg.sv
hdl/search_if.sv
hdl/board_loader.sv
hdl/five_detect.sv
hdl/kill_node.sv
hdl/search_result.sv
hdl/threat_search_top.sv
test/threat_search_assert.sv
test/threat_search_tb.sv

// ==== Makefile ====
TOP := threat_search_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard hdl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; exit $$rc
	! grep -q "SIMULATION FAILED" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== test/threat_search_vectors.txt ====
// per test: rows 0..6 as row words (2 bits per column, column 0 lowest, 1 black, 2 white)
// then a command word: bit 8 busy interference, bits 5:4 depth, bit 0 expected win
// four with one open end, depth 0
0 0 0 156 0 0 0
001
// scattered black stones, depth 0
41 0 0 0 400 0 10
000
// open three, depth 1
0 0 0 150 0 0 0
011
// same open three, depth 0
0 0 0 150 0 0 0
000
// blocked black three against an open white four, depth 1
0 0 0 158 0 2A8 0
010
// first board again with dropped writes and starts while busy
0 0 0 156 0 0 0
101
